// ==== common/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    // ------------------------------
    // angle
    // ------------------------------
    // degrees 0 to 179
    localparam int ANGLE_W = 8;

    typedef logic [ANGLE_W-1:0] angle_t;

    // scan mode and direction thresholds
    localparam angle_t ANGLE_45 = angle_t'(45);
    localparam angle_t ANGLE_90 = angle_t'(90);
    localparam angle_t ANGLE_135 = angle_t'(135);

    // ------------------------------
    // filtered data and addressing
    // ------------------------------
    localparam int DATA_W = 12;
    // addresses wrap modulo 1024
    localparam int S_W = 10;
    localparam int ACCU_W = 12;

    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic [S_W-1:0] s_addr_t;

    // ------------------------------
    // partitioning and line sizes
    // ------------------------------
    // one tap per pe partition
    localparam int N_PART = 4;
    // lines per angle
    localparam int PART_SIZE = 4;
    // samples per line
    localparam int FILL_LEN = 8;
    // tap windows per line
    localparam int SHIFT_LEN = FILL_LEN - N_PART + 1;

    // counter widths
    localparam int LINE_W = $clog2(PART_SIZE);
    localparam int FILL_IDX_W = $clog2(FILL_LEN);
    localparam int WIN_W = $clog2(SHIFT_LEN);

    // scan encodings for the pes
    localparam logic SCAN_MODE_X = 1'b0;
    localparam logic SCAN_MODE_Y = 1'b1;
    localparam logic SCAN_DIR_FWD = 1'b0;
    localparam logic SCAN_DIR_REV = 1'b1;

    // ------------------------------
    // bundles
    // ------------------------------
    // tap 0 is the oldest sample of the window
    typedef struct packed {
        sample_t [N_PART-1:0] tap;
    } pe_taps_t;

    // pe control word
    typedef struct packed {
        logic reset;
        logic kick;
        logic en;
        logic scan_mode;
        logic scan_direction;
    } pe_ctrl_t;

    // per-angle accumulator constants
    typedef struct packed {
        logic [ACCU_W-1:0] sh_accu_base;
        logic [ACCU_W-1:0] mp_accu_part;
        logic [ACCU_W-1:0] mp_accu_base;
    } accu_lut_t;

endpackage

`default_nettype wire

// ==== rtl/bp_accu_lut.sv ====
`default_nettype none

module bp_accu_lut (
    input  logic              clk,
    input  bp_pkg::angle_t    angle,
    output bp_pkg::accu_lut_t lut
);
    import bp_pkg::*;

    // stand-in for the trig tables, same one-cycle access
    logic [ACCU_W-1:0] sh_base;
    logic [ACCU_W-1:0] mp_part;
    logic [ACCU_W-1:0] mp_base;

    // ------------------------------
    // table contents
    // ------------------------------
    always_comb
    begin
        // angle mod 8, plus 1
        sh_base = ACCU_W'(angle[2:0]) + ACCU_W'(1);
        // twice the angle
        mp_part = ACCU_W'({angle, 1'b0});
        // angle mod 4, plus 1
        mp_base = ACCU_W'(angle[1:0]) + ACCU_W'(1);
    end

    // registered read
    always_ff @(posedge clk)
    begin
        lut.sh_accu_base <= sh_base;
        lut.mp_accu_part <= mp_part;
        lut.mp_accu_base <= mp_base;
    end

endmodule

`default_nettype wire

// ==== swap_control/bp_swappable.sv ====
`default_nettype none

module bp_swappable (
    input  logic                      clk,
    input  logic                      reset_n,
    // from swap control
    input  logic [bp_pkg::ACCU_W-1:0] mp_accu_init,
    input  logic [bp_pkg::ACCU_W-1:0] sh_accu_base,
    input  logic                      swap_ack,
    input  logic                      next_itr_ack,
    // filtered RAM data, one cycle after its address
    input  bp_pkg::sample_t           fr_val,
    // status to swap control
    output logic                      swap,
    output logic                      next_itr,
    output logic                      pe_en,
    // filtered RAM address
    output bp_pkg::s_addr_t           fr_s_val,
    output bp_pkg::pe_taps_t          pe_taps
);
    import bp_pkg::*;

    typedef enum logic [1:0] {
        SW_IDLE,
        SW_FILL,
        SW_FULL,
        SW_SHIFT
    } sw_state_t;

    sw_state_t state;

    // address issue side
    logic issuing;
    logic [FILL_IDX_W-1:0] fill_cnt;
    logic [ACCU_W-1:0] s_accu;
    // capture side, one cycle behind issue
    logic cap_vld;
    logic [FILL_IDX_W-1:0] cap_idx;
    // window pointer while shifting
    logic [WIN_W-1:0] win;

    sample_t line_buf [FILL_LEN];

    assign next_itr = (state == SW_IDLE);
    assign swap = (state == SW_FULL);
    assign pe_en = (state == SW_SHIFT);
    assign fr_s_val = s_accu[S_W-1:0];

    // ------------------------------
    // sequencing
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= SW_IDLE;
            issuing <= 1'b0;
            fill_cnt <= '0;
            cap_vld <= 1'b0;
            win <= '0;
        end
        else
        begin
            cap_vld <= issuing;
            case (state)
                SW_IDLE:
                    if (next_itr_ack)
                    begin
                        state <= SW_FILL;
                        issuing <= 1'b1;
                        fill_cnt <= '0;
                    end
                SW_FILL:
                begin
                    if (issuing)
                    begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (fill_cnt == FILL_IDX_W'(FILL_LEN - 1))
                            issuing <= 1'b0;
                    end
                    // full once the last sample lands
                    if (cap_vld && cap_idx == FILL_IDX_W'(FILL_LEN - 1))
                        state <= SW_FULL;
                end
                SW_FULL:
                    if (swap_ack)
                    begin
                        state <= SW_SHIFT;
                        win <= '0;
                    end
                SW_SHIFT:
                    if (win == WIN_W'(SHIFT_LEN - 1))
                        state <= SW_IDLE;
                    else
                        win <= win + 1'b1;
                default:
                    state <= SW_IDLE;
            endcase
        end
    end

    // address k = init + k * base, low bits only
    always_ff @(posedge clk)
    begin
        if (state == SW_IDLE && next_itr_ack)
            s_accu <= mp_accu_init;
        else if (issuing)
            s_accu <= s_accu + sh_accu_base;
        cap_idx <= fill_cnt;
        if (cap_vld)
            line_buf[cap_idx] <= fr_val;
    end

    // ------------------------------
    // tap window
    // ------------------------------
    // window j holds samples j to j + N_PART - 1
    always_comb
    begin
        for (int i = 0; i < N_PART; i++)
            pe_taps.tap[i] = line_buf[FILL_IDX_W'(int'(win) + i)];
    end

    a_swap_ack_full: assert property (@(posedge clk) disable iff (!reset_n)
        swap_ack |-> swap)
        else $error("swap ack while not full");

    a_itr_ack_idle: assert property (@(posedge clk) disable iff (!reset_n)
        next_itr_ack |-> next_itr)
        else $error("next itr ack while busy");

endmodule

`default_nettype wire

// ==== swap_control/bp_swap_control.sv ====
`default_nettype none

module bp_swap_control (
    input  logic                      clk,
    input  logic                      reset_n,
    // filtered RAM side
    input  bp_pkg::angle_t            fr_angle,
    input  logic                      fr_next_angle_ack,
    // constants for the current angle
    input  bp_pkg::accu_lut_t         lut,
    // status from the swappables
    input  logic                      sw0_swap,
    input  logic                      sw1_swap,
    input  logic                      sw0_next_itr,
    input  logic                      sw1_next_itr,
    input  logic                      sw0_pe_en,
    input  logic                      sw1_pe_en,
    input  bp_pkg::pe_taps_t          sw0_taps,
    input  bp_pkg::pe_taps_t          sw1_taps,
    // acks to the swappables
    output logic                      sw0_swap_ack,
    output logic                      sw1_swap_ack,
    output logic                      sw0_next_itr_ack,
    output logic                      sw1_next_itr_ack,
    output logic [bp_pkg::ACCU_W-1:0] mp_accu_init,
    output logic [bp_pkg::ACCU_W-1:0] sh_accu_base,
    // angle request
    output logic                      fr_next_angle,
    // pe side
    output bp_pkg::pe_ctrl_t          pe_ctrl,
    output bp_pkg::pe_taps_t          pe_taps
);
    import bp_pkg::*;

    typedef enum logic [2:0] {
        ST_READY,
        ST_SETUP,
        ST_FILL,
        ST_FILL_AND_SHIFT,
        ST_SHIFT
    } state_t;

    state_t state;
    state_t next_state;

    // sw_sel picks the filling side, the other one shifts
    logic sw_sel;
    logic [LINE_W-1:0] line_cnt;

    // init of the line after the one being started
    logic [ACCU_W-1:0] mp_accu;
    logic [ACCU_W-1:0] mp_accu_base;
    logic scan_mode;
    logic scan_direction;

    // a = filling side, b = shifting side
    logic swa_swap;
    logic swa_next_itr;
    logic swb_next_itr;
    logic swa_next_itr_ack;
    logic swb_next_itr_ack;
    logic swap_ack;
    logic has_next_itr;

    // ------------------------------
    // ping-pong demux
    // ------------------------------
    assign swa_swap = sw_sel ? sw1_swap : sw0_swap;
    assign swa_next_itr = sw_sel ? sw1_next_itr : sw0_next_itr;
    assign swb_next_itr = sw_sel ? sw0_next_itr : sw1_next_itr;

    // swap once the filled side meets an idle partner
    assign swap_ack = (state == ST_FILL || state == ST_FILL_AND_SHIFT) &&
                      swa_swap && swb_next_itr;
    // first line of an angle
    assign swa_next_itr_ack = (state == ST_SETUP) && swa_next_itr;
    // later lines go to the side that just went idle
    assign swb_next_itr_ack = swap_ack && has_next_itr;
    assign has_next_itr = (line_cnt != LINE_W'(PART_SIZE - 1));

    assign sw0_next_itr_ack = sw_sel ? swb_next_itr_ack : swa_next_itr_ack;
    assign sw1_next_itr_ack = sw_sel ? swa_next_itr_ack : swb_next_itr_ack;
    assign sw0_swap_ack = sw_sel ? 1'b0 : swap_ack;
    assign sw1_swap_ack = sw_sel ? swap_ack : 1'b0;

    // line 0 takes the look-up value directly, later lines the stepped one
    assign mp_accu_init = (state == ST_SETUP) ? lut.mp_accu_part : mp_accu;

    assign fr_next_angle = (state == ST_READY) || (state == ST_SHIFT && swb_next_itr);

    // ------------------------------
    // FSM
    // ------------------------------
    always_comb
    begin
        next_state = state;
        case (state)
            ST_READY:
                if (fr_next_angle_ack)
                    next_state = ST_SETUP;
            ST_SETUP:
                if (swa_next_itr)
                    next_state = ST_FILL;
            ST_FILL:
                if (swap_ack)
                    next_state = has_next_itr ? ST_FILL_AND_SHIFT : ST_SHIFT;
            ST_FILL_AND_SHIFT:
                if (swap_ack && !has_next_itr)
                    next_state = ST_SHIFT;
            // last line shifting, request may be acked straight away
            ST_SHIFT:
                if (swb_next_itr)
                    next_state = fr_next_angle_ack ? ST_SETUP : ST_READY;
            default:
                next_state = ST_READY;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ST_READY;
            sw_sel <= 1'b0;
            line_cnt <= '0;
            scan_mode <= SCAN_MODE_X;
            scan_direction <= SCAN_DIR_FWD;
        end
        else
        begin
            state <= next_state;
            if (swap_ack)
                sw_sel <= !sw_sel;
            if (state == ST_SETUP)
                line_cnt <= '0;
            else if (swap_ack)
                line_cnt <= line_cnt + 1'b1;
            // x below 45 or from 135 up, reverse from 90 up
            if (state == ST_SETUP)
            begin
                if (fr_angle < ANGLE_45 || fr_angle >= ANGLE_135)
                    scan_mode <= SCAN_MODE_X;
                else
                    scan_mode <= SCAN_MODE_Y;
                if (fr_angle < ANGLE_90)
                    scan_direction <= SCAN_DIR_FWD;
                else
                    scan_direction <= SCAN_DIR_REV;
            end
        end
    end

    // mapper accumulator, steps down by base each line
    always_ff @(posedge clk)
    begin
        if (state == ST_SETUP)
        begin
            mp_accu <= lut.mp_accu_part - lut.mp_accu_base;
            mp_accu_base <= lut.mp_accu_base;
            sh_accu_base <= lut.sh_accu_base;
        end
        else if (swap_ack)
            mp_accu <= mp_accu - mp_accu_base;
    end

    // ------------------------------
    // pe outputs
    // ------------------------------
    always_comb
    begin
        pe_ctrl.reset = swa_next_itr_ack;
        pe_ctrl.kick = swap_ack;
        pe_ctrl.en = sw_sel ? sw0_pe_en : sw1_pe_en;
        pe_ctrl.scan_mode = scan_mode;
        pe_ctrl.scan_direction = scan_direction;
    end

    // taps from the shifting side
    assign pe_taps = sw_sel ? sw0_taps : sw1_taps;

    // checks
    a_swap_ack_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(sw0_swap_ack && sw1_swap_ack))
        else $error("both swap acks high");

    a_angle_ack_req: assert property (@(posedge clk) disable iff (!reset_n)
        fr_next_angle_ack |-> fr_next_angle)
        else $error("angle ack without request");

    a_state_legal: assert property (@(posedge clk) disable iff (!reset_n)
        state inside {ST_READY, ST_SETUP, ST_FILL, ST_FILL_AND_SHIFT, ST_SHIFT})
        else $error("illegal state %0d", state);

endmodule

`default_nettype wire

// ==== rtl/bp_processing.sv ====
`default_nettype none

module bp_processing (
    input  logic              clk,
    input  logic              reset_n,
    // filtered RAM side
    input  bp_pkg::angle_t    fr_angle,
    input  logic              fr_next_angle_ack,
    input  bp_pkg::sample_t   fr0_val,
    input  bp_pkg::sample_t   fr1_val,
    output logic              fr_next_angle,
    output bp_pkg::s_addr_t   fr0_s_val,
    output bp_pkg::s_addr_t   fr1_s_val,
    // pe side
    output bp_pkg::pe_ctrl_t  pe_ctrl,
    output bp_pkg::pe_taps_t  pe_taps
);
    import bp_pkg::*;

    accu_lut_t lut;
    logic [ACCU_W-1:0] mp_accu_init;
    logic [ACCU_W-1:0] sh_accu_base;

    // swappable handshakes
    logic sw0_swap;
    logic sw1_swap;
    logic sw0_next_itr;
    logic sw1_next_itr;
    logic sw0_pe_en;
    logic sw1_pe_en;
    logic sw0_swap_ack;
    logic sw1_swap_ack;
    logic sw0_next_itr_ack;
    logic sw1_next_itr_ack;
    pe_taps_t sw0_taps;
    pe_taps_t sw1_taps;

    // ------------------------------
    // look-up and control
    // ------------------------------
    bp_accu_lut u_accu_lut (
        .clk   (clk),
        .angle (fr_angle),
        .lut   (lut)
    );

    bp_swap_control u_swap_control (
        .clk               (clk),
        .reset_n           (reset_n),
        .fr_angle          (fr_angle),
        .fr_next_angle_ack (fr_next_angle_ack),
        .lut               (lut),
        .sw0_swap          (sw0_swap),
        .sw1_swap          (sw1_swap),
        .sw0_next_itr      (sw0_next_itr),
        .sw1_next_itr      (sw1_next_itr),
        .sw0_pe_en         (sw0_pe_en),
        .sw1_pe_en         (sw1_pe_en),
        .sw0_taps          (sw0_taps),
        .sw1_taps          (sw1_taps),
        .sw0_swap_ack      (sw0_swap_ack),
        .sw1_swap_ack      (sw1_swap_ack),
        .sw0_next_itr_ack  (sw0_next_itr_ack),
        .sw1_next_itr_ack  (sw1_next_itr_ack),
        .mp_accu_init      (mp_accu_init),
        .sh_accu_base      (sh_accu_base),
        .fr_next_angle     (fr_next_angle),
        .pe_ctrl           (pe_ctrl),
        .pe_taps           (pe_taps)
    );

    // ------------------------------
    // ping-pong line buffers
    // ------------------------------
    bp_swappable u_sw0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .mp_accu_init (mp_accu_init),
        .sh_accu_base (sh_accu_base),
        .swap_ack     (sw0_swap_ack),
        .next_itr_ack (sw0_next_itr_ack),
        .fr_val       (fr0_val),
        .swap         (sw0_swap),
        .next_itr     (sw0_next_itr),
        .pe_en        (sw0_pe_en),
        .fr_s_val     (fr0_s_val),
        .pe_taps      (sw0_taps)
    );

    bp_swappable u_sw1 (
        .clk          (clk),
        .reset_n      (reset_n),
        .mp_accu_init (mp_accu_init),
        .sh_accu_base (sh_accu_base),
        .swap_ack     (sw1_swap_ack),
        .next_itr_ack (sw1_next_itr_ack),
        .fr_val       (fr1_val),
        .swap         (sw1_swap),
        .next_itr     (sw1_next_itr),
        .pe_en        (sw1_pe_en),
        .fr_s_val     (fr1_s_val),
        .pe_taps      (sw1_taps)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 2;

    // 4 ns period
    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    // release on a falling edge, same as the other inputs
    initial
    begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES)
            @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/tb_bp_processing.sv ====
`default_nettype none

module tb_bp_processing;
    timeunit 1ns;
    timeprecision 100ps;

    import bp_pkg::*;

    localparam int MAX_ANGLES = 12;
    localparam int SEED_WORDS = 16;
    localparam int STIM_WORDS = SEED_WORDS + 1 + 3 * MAX_ANGLES;

    logic clk;
    logic reset_n;
    angle_t fr_angle;
    logic fr_next_angle_ack;
    sample_t fr0_val = '0;
    sample_t fr1_val = '0;
    logic fr_next_angle;
    s_addr_t fr0_s_val;
    s_addr_t fr1_s_val;
    pe_ctrl_t pe_ctrl;
    pe_taps_t pe_taps;

    // file image and decoded fields
    logic [11:0] stim [STIM_WORDS];
    sample_t ram_seed [SEED_WORDS];
    angle_t ang [MAX_ANGLES];
    logic exp_mode [MAX_ANGLES];
    logic exp_dir [MAX_ANGLES];
    int n_angles = 0;
    logic loaded = 1'b0;
    integer seed;

    // progress per angle
    int ack_cnt = 0;
    int reset_cnt [MAX_ANGLES];
    int kick_cnt [MAX_ANGLES];
    int fills_started = 0;
    int win_cnt = 0;
    logic have_line = 1'b0;

    // line being filled
    logic fill_active = 1'b0;
    logic fill_side = 1'b0;
    int fill_k = 0;
    int fill_init = 0;
    int fill_step = 0;

    // addresses of filled lines, oldest first
    s_addr_t line_q [$];
    s_addr_t shift_addr [FILL_LEN];

    // RAM model pipeline
    s_addr_t last_addr0;
    s_addr_t last_addr1;

    tb_clock_gen u_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    bp_processing u_bp_processing (
        .clk               (clk),
        .reset_n           (reset_n),
        .fr_angle          (fr_angle),
        .fr_next_angle_ack (fr_next_angle_ack),
        .fr0_val           (fr0_val),
        .fr1_val           (fr1_val),
        .fr_next_angle     (fr_next_angle),
        .fr0_s_val         (fr0_s_val),
        .fr1_s_val         (fr1_s_val),
        .pe_ctrl           (pe_ctrl),
        .pe_taps           (pe_taps)
    );

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_addr(input string name, input s_addr_t got, input s_addr_t exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_taps(input string name, input pe_taps_t got, input pe_taps_t exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_ctrl(input string name, input pe_ctrl_t got, input pe_ctrl_t exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // RAM word depends on every address bit
    function automatic sample_t ram_word(input s_addr_t a);
        return ram_seed[a[3:0]] ^ sample_t'({a, 2'b01});
    endfunction

    // pe_ctrl outside the reset pulse
    function automatic pe_ctrl_t ctrl_expect(input logic kick, input logic en, input int idx);
        pe_ctrl_t c;
        c.reset = 1'b0;
        c.kick = kick;
        c.en = en;
        c.scan_mode = exp_mode[idx];
        c.scan_direction = exp_dir[idx];
        return c;
    endfunction

    // line L starts at 2*angle - L*(angle mod 4 + 1)
    // step is angle mod 8 + 1
    task automatic start_fill(input int idx, input int line);
        int a;
        a = int'(ang[idx]);
        fill_init = 2 * a - line * (a % 4 + 1);
        fill_step = a % 8 + 1;
        // even lines from reset on sw0
        fill_side = fills_started[0];
        fills_started++;
        fill_k = 0;
        fill_active = 1'b1;
    endtask

    task automatic check_angle_counts(input int idx);
        if (reset_cnt[idx] != 1)
            report_failure($sformatf("angle %0d gave %0d PE reset pulses instead of one",
                                     ang[idx], reset_cnt[idx]));
        if (kick_cnt[idx] != PART_SIZE)
            report_failure($sformatf("angle %0d gave %0d kick pulses instead of %0d",
                                     ang[idx], kick_cnt[idx], PART_SIZE));
    endtask

    // ------------------------------
    // filtered RAM model
    // ------------------------------
    // data one cycle after the address
    always @(negedge clk)
    begin
        fr0_val = ram_word(last_addr0);
        fr1_val = ram_word(last_addr1);
        last_addr0 = fr0_s_val;
        last_addr1 = fr1_s_val;
    end

    // ------------------------------
    // output monitor
    // ------------------------------
    always @(negedge clk)
    begin : monitor
        int cur;
        s_addr_t exp_addr;
        pe_taps_t exp_taps;
        if (reset_n && loaded)
        begin
            cur = ack_cnt - 1;
            // address stream of the filling side
            if (fill_active)
            begin
                exp_addr = s_addr_t'(fill_init + fill_k * fill_step);
                if (fill_side)
                    check_addr("fr1_s_val", fr1_s_val, exp_addr);
                else
                    check_addr("fr0_s_val", fr0_s_val, exp_addr);
                line_q.push_back(exp_addr);
                fill_k++;
                if (fill_k == FILL_LEN)
                    fill_active = 1'b0;
            end
            // windows of the shifting side in order
            if (pe_ctrl.en)
            begin
                if (!have_line)
                    report_failure("pe_ctrl.en went high before any kick");
                if (win_cnt >= SHIFT_LEN)
                    report_failure("pe_ctrl.en stayed high past the last window");
                for (int i = 0; i < N_PART; i++)
                    exp_taps.tap[i] = ram_word(shift_addr[win_cnt + i]);
                check_taps("pe_taps", pe_taps, exp_taps);
                check_ctrl("pe_ctrl", pe_ctrl, ctrl_expect(1'b0, 1'b1, cur));
                win_cnt++;
            end
            if ((pe_ctrl.reset || pe_ctrl.kick) && cur < 0)
                report_failure("PE pulse before the first angle was accepted");
            // first line of an angle
            if (pe_ctrl.reset)
            begin
                reset_cnt[cur]++;
                start_fill(cur, 0);
            end
            // swap moves the oldest filled line to shifting
            if (pe_ctrl.kick)
            begin
                check_ctrl("pe_ctrl", pe_ctrl, ctrl_expect(1'b1, 1'b0, cur));
                if (have_line && win_cnt != SHIFT_LEN)
                    report_failure("previous line did not shift all its windows");
                if (line_q.size() < FILL_LEN)
                    report_failure("kick before the line was filled");
                for (int i = 0; i < FILL_LEN; i++)
                    shift_addr[i] = line_q.pop_front();
                have_line = 1'b1;
                win_cnt = 0;
                kick_cnt[cur]++;
                // next fill goes to the idle side while lines remain
                if (kick_cnt[cur] < PART_SIZE)
                    start_fill(cur, kick_cnt[cur]);
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial
    begin : main
        int delay;
        fr_angle = '0;
        fr_next_angle_ack = 1'b0;
        seed = 32'hf67a_985a;
        $readmemh("verification/bp_stimulus.txt", stim);
        for (int i = 0; i < SEED_WORDS; i++)
            ram_seed[i] = sample_t'(stim[i]);
        n_angles = int'(stim[SEED_WORDS]);
        if (n_angles < 1 || n_angles > MAX_ANGLES)
            report_failure("stimulus file missing or its angle count is out of range");
        for (int n = 0; n < MAX_ANGLES; n++)
        begin
            reset_cnt[n] = 0;
            kick_cnt[n] = 0;
            if (n < n_angles)
            begin
                ang[n] = angle_t'(stim[SEED_WORDS + 1 + 3 * n]);
                exp_mode[n] = stim[SEED_WORDS + 2 + 3 * n][0];
                exp_dir[n] = stim[SEED_WORDS + 3 + 3 * n][0];
            end
        end
        loaded = 1'b1;

        // idle state right after reset
        @(posedge reset_n);
        check_ctrl("pe_ctrl", pe_ctrl, '0);
        check_bit("fr_next_angle", fr_next_angle, 1'b1);

        for (int n = 0; n < n_angles; n++)
        begin
            while (!fr_next_angle)
                @(negedge clk);
            // ack delayed by 0 to 3 cycles
            delay = $unsigned($random(seed)) % 4;
            repeat (delay)
                @(negedge clk);
            check_bit("fr_next_angle", fr_next_angle, 1'b1);
            if (n > 0)
                check_angle_counts(n - 1);
            fr_angle = ang[n];
            fr_next_angle_ack = 1'b1;
            ack_cnt++;
            @(negedge clk);
            fr_next_angle_ack = 1'b0;
        end

        // last line has left the shifting side
        while (!fr_next_angle)
            @(negedge clk);
        @(posedge clk);
        check_angle_counts(n_angles - 1);
        if (win_cnt != SHIFT_LEN)
            report_failure("last line did not shift all its windows");
        else if (fills_started != n_angles * PART_SIZE || line_q.size() != 0)
            report_failure("number of filled lines does not match the angle count");
        else
        begin
            $display("TEST OK");
            $finish;
        end
    end

    // ------------------------------
    // watchdog
    // ------------------------------
    initial
    begin : watchdog
        int limit;
        wait (loaded);
        limit = n_angles * PART_SIZE * 40 + 200;
        repeat (limit)
            @(posedge clk);
        report_failure($sformatf("timeout, angles not done within %0d cycles", limit));
    end

endmodule

`default_nettype wire

// ==== verification/bp_stimulus.txt ====
// 16 RAM seed words (hex), word at address a = seed[a mod 16] xor {a, 2'b01}
// then the angle count, then per angle: angle  scan_mode (0 x, 1 y)  scan_direction (0 fwd, 1 rev)
3a5 c17 0f2 8e9
51d a60 2b4 f3c
7d8 146 9cb e02
63f b71 d8a 4e3
// number of angles
00c
// angle mode dir
000 0 0 // 0 deg
01e 0 0 // 30 deg
02c 0 0 // 44 deg
02d 1 0 // 45 deg
059 1 0 // 89 deg
05a 1 1 // 90 deg
064 1 1 // 100 deg
086 1 1 // 134 deg
087 0 1 // 135 deg
0b3 0 1 // 179 deg
096 0 1 // 150 deg
007 0 0 // 7 deg

// ==== sim.f ====
common/bp_pkg.sv
rtl/bp_accu_lut.sv
swap_control/bp_swappable.sv
swap_control/bp_swap_control.sv
rtl/bp_processing.sv
verification/tb_clock_gen.sv
verification/tb_bp_processing.sv
